// File: all.f
+incdir+include
hdl/cache_pkg.sv
hdl/cache_req_router.sv
hdl/cache_bank.sv
hdl/cache_resp_merge.sv
hdl/banked_cache_top.sv
bench/cache_checker.sv
bench/cache_assertions.sv
bench/tb_banked_cache.sv

// File: run.sh
#!/bin/sh
# Build and run the banked cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_banked_cache -f all.f -o sim_banked_cache
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_banked_cache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// File: bench/tb_banked_cache.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_banked_cache;

    localparam int          HALF_PERIOD_NS = 2;                 // 4 ns clock
    localparam int          RESET_CYCLES   = 16;
    localparam int          NUM_REQS       = 2000;
    localparam int          TIMEOUT_CYCLES = NUM_REQS * 4;      // Room for idle and stalled cycles
    localparam logic [31:0] LFSR_SEED      = 32'd16;
    localparam logic [31:0] LFSR_TAPS      = 32'hD000_0001;     // x^32 + x^31 + x^29 + x + 1

    logic                     clk;
    logic                     reset_i;
    logic                     req_valid_i;
    logic                     req_ready_o;
    logic [`CACHE_ADDR_W-1:0] req_addr_i;
    logic                     req_wr_i;
    logic [`CACHE_DATA_W-1:0] req_wdata_i;
    logic [3:0]               req_be_i;
    logic [`CACHE_DATA_W-1:0] req_fill_i;
    logic                     resp_valid_o;
    logic                     resp_ready_i;
    logic                     resp_hit_o;
    logic                     resp_err_o;
    logic [`CACHE_DATA_W-1:0] resp_rdata_o;

    int          errors;
    int          checked;
    int          pending;       // Responses the checker still waits for
    int          cycle_cnt = 0;
    int          sent;          // Requests accepted by the DUT
    logic [31:0] lfsr_state;
    logic [31:0] rnd;

    always #(HALF_PERIOD_NS) clk = ~clk;

    banked_cache_top u_banked_cache_top (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_addr_i   (req_addr_i),
        .req_wr_i     (req_wr_i),
        .req_wdata_i  (req_wdata_i),
        .req_be_i     (req_be_i),
        .req_fill_i   (req_fill_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_hit_o   (resp_hit_o),
        .resp_err_o   (resp_err_o),
        .resp_rdata_o (resp_rdata_o)
    );

    cache_checker u_cache_checker (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_ready_i  (req_ready_o),
        .req_addr_i   (req_addr_i),
        .req_wr_i     (req_wr_i),
        .req_wdata_i  (req_wdata_i),
        .req_be_i     (req_be_i),
        .req_fill_i   (req_fill_i),
        .resp_valid_i (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_hit_i   (resp_hit_o),
        .resp_err_i   (resp_err_o),
        .resp_rdata_i (resp_rdata_o),
        .errors_o     (errors),
        .checked_o    (checked),
        .pending_o    (pending)
    );

    // Right-shift Galois step
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};  // One step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Eight tags, tag 7 differs from tag 0 only in addr[1:0]
    function automatic logic [31:0] pool_addr(input logic [2:0] tag_idx,
                                              input logic [1:0] bank, input logic set_sel);
        logic [21:0] hi;
        logic [1:0]  lo;
        hi = (tag_idx == 3'd7) ? 22'h0000A5 : 22'h0000A5 + 22'h0001C3 * 22'(tag_idx);
        lo = (tag_idx == 3'd7) ? 2'b01 : 2'b00;
        return {hi, (set_sel ? 6'd37 : 6'd0), bank, lo};     // Two sets per bank
    endfunction

    task automatic drive_request();
        logic [31:0] tag_idx;
        logic [31:0] bank;
        logic [31:0] set_sel;
        logic [31:0] v;
        take_bits(3, tag_idx);
        take_bits(2, bank);
        take_bits(1, set_sel);
        req_addr_i <= pool_addr(tag_idx[2:0], bank[1:0], set_sel[0]);
        take_bits(1, v);
        req_wr_i <= v[0];
        take_bits(3, v);
        case (v[2:0])
            3'd0, 3'd1: req_be_i <= 4'b0001;
            3'd2, 3'd3: req_be_i <= 4'b0011;
            3'd7: begin
                take_bits(2, v);                        // Pick one of four illegal codes
                req_be_i <= {v[1], 2'b11 & {2{v[0]}}, 1'b0};
            end
            default:    req_be_i <= 4'b1111;
        endcase
        take_bits(32, v);
        req_wdata_i <= v;
        take_bits(32, v);
        req_fill_i  <= v;
        req_valid_i <= 1'b1;
    endtask

    task automatic drive_resp_ready();
        logic [31:0] v;
        take_bits(2, v);
        resp_ready_i <= (v[1:0] != 2'b00);              // Low about a quarter of the time
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        reset_i      = 1'b1;
        req_valid_i  = 1'b0;
        req_addr_i   = '0;
        req_wr_i     = 1'b0;
        req_wdata_i  = '0;
        req_be_i     = 4'b0000;
        req_fill_i   = '0;
        resp_ready_i = 1'b0;
        lfsr_state   = LFSR_SEED;
        sent         = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;

        while (sent < NUM_REQS) begin
            @(posedge clk);
            if (req_valid_i && req_ready_o) begin
                sent++;                                 // Transfer at this edge
            end
            if (!req_valid_i || req_ready_o) begin     // Slot free for a new request
                take_bits(3, rnd);
                if (sent < NUM_REQS && rnd[2:0] != 3'd0) begin
                    drive_request();
                end else begin
                    req_valid_i <= 1'b0;                // Idle cycle or done
                end
            end
            drive_resp_ready();
        end

        // Drain the outstanding responses
        while (pending != 0) begin
            @(posedge clk);
            drive_resp_ready();
        end

        $display("Requests: %0d, responses checked: %0d, errors: %0d", sent, checked, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: bench/cache_assertions.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_assertions (
    input logic                     clk,
    input logic                     reset_i,
    input logic [31:0]              issued_cnt_i,   // Dispatch count kept by the router
    input logic                     resp_valid_i,
    input logic                     resp_ready_i,
    input logic                     resp_hit_i,
    input logic                     resp_err_i,
    input logic [`CACHE_DATA_W-1:0] resp_rdata_i
);

    logic [31:0] taken_cnt;     // Responses accepted at the output port

    always_ff @(posedge clk) begin
        if (reset_i) begin
            taken_cnt <= '0;
        end else if (resp_valid_i && resp_ready_i) begin
            taken_cnt <= taken_cnt + 32'd1;
        end
    end

    // Response side holds valid and payload while stalled
    a_resp_valid_held: assert property (@(posedge clk) disable iff (reset_i)
        resp_valid_i && !resp_ready_i |=> resp_valid_i)
        else $error("resp_valid_o dropped before the response was accepted");

    a_resp_payload_stable: assert property (@(posedge clk) disable iff (reset_i)
        resp_valid_i && !resp_ready_i |=> $stable({resp_hit_i, resp_err_i, resp_rdata_i}))
        else $error("response payload changed while stalled");

    // Credit keeps dispatched but unreturned requests within the FIFO
    a_inflight_limit: assert property (@(posedge clk) disable iff (reset_i)
        (issued_cnt_i - taken_cnt) <= 32'(`CACHE_FIFO_DEPTH))
        else $error("more requests in flight than the FIFO can hold");

    a_empty_after_reset: assert property (@(posedge clk) $fell(reset_i) |-> !resp_valid_i)
        else $error("response valid right after reset");

endmodule

bind banked_cache_top cache_assertions u_cache_assertions (
    .clk          (clk),
    .reset_i      (reset_i),
    .issued_cnt_i (u_router.issued_cnt),
    .resp_valid_i (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_hit_i   (resp_hit_o),
    .resp_err_i   (resp_err_o),
    .resp_rdata_i (resp_rdata_o)
);

// File: bench/cache_checker.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_checker
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     req_valid_i,
    input  logic                     req_ready_i,
    input  logic [`CACHE_ADDR_W-1:0] req_addr_i,
    input  logic                     req_wr_i,
    input  logic [`CACHE_DATA_W-1:0] req_wdata_i,
    input  logic [3:0]               req_be_i,
    input  logic [`CACHE_DATA_W-1:0] req_fill_i,
    input  logic                     resp_valid_i,
    input  logic                     resp_ready_i,
    input  logic                     resp_hit_i,
    input  logic                     resp_err_i,
    input  logic [`CACHE_DATA_W-1:0] resp_rdata_i,
    output int                       errors_o,
    output int                       checked_o,
    output int                       pending_o
);

    localparam int BANKS = `CACHE_NUM_BANKS;
    localparam int SETS  = `CACHE_SETS_PER_BANK;
    localparam int WAYS  = `CACHE_NUM_WAYS;

    // Reference cache state
    tag_t        m_tag   [BANKS][SETS][WAYS];
    logic [31:0] m_data  [BANKS][SETS][WAYS];
    int          m_age   [BANKS][SETS][WAYS];
    bit          m_valid [BANKS][SETS][WAYS];

    logic [33:0] exp_q[$];      // {hit, err, rdata} in request order
    int          err_cnt  = 0;
    int          resp_cnt = 0;
    int          pend_cnt = 0;

    assign errors_o  = err_cnt;
    assign checked_o = resp_cnt;
    assign pending_o = pend_cnt;

    // Storage without reset starts at zero, like the DUT arrays in simulation
    task automatic clear_model();
        for (int b = 0; b < BANKS; b++) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    m_tag[b][s][w]   = '0;
                    m_data[b][s][w]  = '0;
                    m_age[b][s][w]   = 0;
                    m_valid[b][s][w] = 1'b0;
                end
            end
        end
        exp_q.delete();
    endtask

    task automatic model_access();
        int          b;
        int          s;
        int          way;
        tag_t        tag;
        logic [31:0] mask;
        logic [31:0] nw;
        logic        hit_e;
        b    = int'(req_addr_i[`CACHE_SET_LSB-1:`CACHE_BANK_LSB]);
        s    = int'(req_addr_i[`CACHE_TAG_LSB-1:`CACHE_SET_LSB]);
        tag  = {req_addr_i[`CACHE_ADDR_W-1:`CACHE_TAG_LSB], req_addr_i[`CACHE_BANK_LSB-1:0]};
        mask = '0;
        case (req_be_i)
            4'b0001: mask = 32'h0000_00FF;
            4'b0011: mask = 32'h0000_FFFF;
            4'b1111: mask = 32'hFFFF_FFFF;
            default: mask = '0;                         // Illegal code
        endcase
        if (mask == '0) begin
            exp_q.push_back({1'b0, 1'b1, 32'h0});       // Error, state untouched
            return;
        end
        way = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (way < 0 && m_valid[b][s][w] && m_tag[b][s][w] == tag) way = w;
        end
        if (way >= 0) begin
            hit_e = 1'b1;
            nw    = m_data[b][s][way];
        end else begin
            hit_e = 1'b0;
            way   = 0;                                  // Oldest way, lowest index on ties
            for (int w = 1; w < WAYS; w++) begin
                if (m_age[b][s][w] > m_age[b][s][way]) way = w;
            end
            nw = req_wr_i ? m_data[b][s][way] : req_fill_i;
        end
        if (req_wr_i) nw = (nw & ~mask) | (req_wdata_i & mask);
        exp_q.push_back({hit_e, 1'b0, nw & mask});
        m_tag[b][s][way]   = tag;
        m_data[b][s][way]  = nw;
        m_valid[b][s][way] = 1'b1;
        for (int w = 0; w < WAYS; w++) begin
            if (w == way) m_age[b][s][w] = 0;
            else if (m_age[b][s][w] < WAYS - 1) m_age[b][s][w]++;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_cnt++;
        $display("** Error: %s = 0x%08h, expected 0x%08h (response %0d)",
                 name, got, exp, resp_cnt);
    endtask

    task automatic check_response();
        logic [33:0] exp;
        if (exp_q.size() == 0) begin
            err_cnt++;
            $display("Response at %0t arrived with no request outstanding", $time);
            return;
        end
        exp = exp_q.pop_front();
        resp_cnt++;
        if (resp_hit_i !== exp[33])     report_mismatch("resp_hit_o", 32'(resp_hit_i), 32'(exp[33]));
        if (resp_err_i !== exp[32])     report_mismatch("resp_err_o", 32'(resp_err_i), 32'(exp[32]));
        if (resp_rdata_i !== exp[31:0]) report_mismatch("resp_rdata_o", resp_rdata_i, exp[31:0]);
    endtask

    // Handshakes are stable mid-cycle, a transfer happens at the next rising edge
    always @(negedge clk) begin
        if (reset_i) begin
            clear_model();
        end else begin
            if (resp_valid_i && resp_ready_i) check_response();
            if (req_valid_i && req_ready_i) model_access();
        end
        pend_cnt = exp_q.size();
    end

endmodule

// File: hdl/banked_cache_top.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module banked_cache_top (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  logic [`CACHE_ADDR_W-1:0] req_addr_i,
    input  logic                     req_wr_i,
    input  logic [`CACHE_DATA_W-1:0] req_wdata_i,
    input  logic [3:0]               req_be_i,
    input  logic [`CACHE_DATA_W-1:0] req_fill_i,
    output logic                     resp_valid_o,
    input  logic                     resp_ready_i,
    output logic                     resp_hit_o,
    output logic                     resp_err_o,
    output logic [`CACHE_DATA_W-1:0] resp_rdata_o
);

    localparam int NB = `CACHE_NUM_BANKS;

    // Router to banks, payload broadcast
    logic [NB-1:0]                     bank_req_valid;
    logic [`CACHE_ADDR_W-1:0]          bank_addr;
    logic                              bank_wr;
    logic [`CACHE_DATA_W-1:0]          bank_wdata;
    logic [3:0]                        bank_be;
    logic [`CACHE_DATA_W-1:0]          bank_fill;

    // Banks to merger
    logic [NB-1:0]                     bank_resp_valid;
    logic [NB-1:0]                     bank_hit;
    logic [NB-1:0]                     bank_err;
    logic [NB-1:0][`CACHE_DATA_W-1:0]  bank_rdata;

    logic                              credit_ok;
    logic                              dispatch;

    assign dispatch = |bank_req_valid;  // Tells the merger a response is on its way

    cache_req_router u_router (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .req_wr_i     (req_wr_i),
        .req_wdata_i  (req_wdata_i),
        .req_be_i     (req_be_i),
        .req_fill_i   (req_fill_i),
        .credit_ok_i  (credit_ok),
        .req_ready_o  (req_ready_o),
        .bank_valid_o (bank_req_valid),
        .bank_addr_o  (bank_addr),
        .bank_wr_o    (bank_wr),
        .bank_wdata_o (bank_wdata),
        .bank_be_o    (bank_be),
        .bank_fill_o  (bank_fill)
    );

    for (genvar b = 0; b < NB; b++) begin : g_bank
        cache_bank u_bank (
            .clk          (clk),
            .reset_i      (reset_i),
            .valid_i      (bank_req_valid[b]),
            .addr_i       (bank_addr),
            .wr_i         (bank_wr),
            .wdata_i      (bank_wdata),
            .be_i         (bank_be),
            .fill_i       (bank_fill),
            .resp_valid_o (bank_resp_valid[b]),
            .hit_o        (bank_hit[b]),
            .err_o        (bank_err[b]),
            .rdata_o      (bank_rdata[b])
        );
    end

    cache_resp_merge u_merge (
        .clk          (clk),
        .reset_i      (reset_i),
        .bank_valid_i (bank_resp_valid),
        .bank_hit_i   (bank_hit),
        .bank_err_i   (bank_err),
        .bank_rdata_i (bank_rdata),
        .dispatch_i   (dispatch),
        .resp_ready_i (resp_ready_i),
        .resp_valid_o (resp_valid_o),
        .resp_hit_o   (resp_hit_o),
        .resp_err_o   (resp_err_o),
        .resp_rdata_o (resp_rdata_o),
        .credit_ok_o  (credit_ok)
    );

endmodule

// File: hdl/cache_resp_merge.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_resp_merge
    import cache_pkg::*;
(
    input  logic                                            clk,
    input  logic                                            reset_i,
    input  logic [`CACHE_NUM_BANKS-1:0]                     bank_valid_i,   // At most one high
    input  logic [`CACHE_NUM_BANKS-1:0]                     bank_hit_i,
    input  logic [`CACHE_NUM_BANKS-1:0]                     bank_err_i,
    input  logic [`CACHE_NUM_BANKS-1:0][`CACHE_DATA_W-1:0]  bank_rdata_i,
    input  logic                                            dispatch_i,     // Request sent to a bank
    input  logic                                            resp_ready_i,
    output logic                                            resp_valid_o,
    output logic                                            resp_hit_o,
    output logic                                            resp_err_o,
    output logic [`CACHE_DATA_W-1:0]                        resp_rdata_o,
    output logic                                            credit_ok_o
);

    localparam int DEPTH = `CACHE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    bank_id_t                 sel;
    logic                     push;
    logic                     pop;
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [CNT_W-1:0]         count;        // Entries held in the FIFO
    logic [CNT_W-1:0]         inflight;     // Dispatched, bank response not yet stored
    logic                     fifo_hit  [DEPTH];
    logic                     fifo_err  [DEPTH];
    logic [`CACHE_DATA_W-1:0] fifo_data [DEPTH];

    // Pick the one responding bank
    always_comb begin
        sel = '0;
        for (int b = 0; b < `CACHE_NUM_BANKS; b++) begin
            if (bank_valid_i[b]) begin
                sel = bank_id_t'(b);
            end
        end
    end

    assign push = |bank_valid_i;
    assign pop  = resp_valid_o && resp_ready_i;

    // Head of the FIFO drives the response port directly
    assign resp_valid_o = (count != '0);
    assign resp_hit_o   = fifo_hit[rd_ptr];
    assign resp_err_o   = fifo_err[rd_ptr];
    assign resp_rdata_o = fifo_data[rd_ptr];

    // Stored plus in-flight may not exceed the FIFO, so a push always finds room
    assign credit_ok_o = ({1'b0, count} + {1'b0, inflight}) < (CNT_W + 1)'(DEPTH);

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_hit[wr_ptr]  <= bank_hit_i[sel];
            fifo_err[wr_ptr]  <= bank_err_i[sel];
            fifo_data[wr_ptr] <= bank_rdata_i[sel];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            inflight <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at the depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count + CNT_W'(push) - CNT_W'(pop);
            inflight <= inflight + CNT_W'(dispatch_i) - CNT_W'(push);
        end
    end

endmodule

// File: hdl/cache_bank.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_bank
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     valid_i,       // Dispatch from the router
    input  logic [`CACHE_ADDR_W-1:0] addr_i,
    input  logic                     wr_i,
    input  logic [`CACHE_DATA_W-1:0] wdata_i,
    input  logic [3:0]               be_i,
    input  logic [`CACHE_DATA_W-1:0] fill_i,        // Next-level word, loaded on a read miss
    output logic                     resp_valid_o,
    output logic                     hit_o,
    output logic                     err_o,
    output logic [`CACHE_DATA_W-1:0] rdata_o
);

    localparam int         SETS    = `CACHE_SETS_PER_BANK;
    localparam int         WAYS    = `CACHE_NUM_WAYS;
    localparam int         SET_W   = $clog2(SETS);
    localparam int         WAY_W   = $clog2(WAYS);
    localparam logic [2:0] AGE_MAX = 3'(WAYS - 1);   // Ages saturate here

    // Storage, one entry per set and way
    tag_t              tag_arr   [SETS][WAYS];
    cache_word_u       data_arr  [SETS][WAYS];
    logic [2:0]        age_arr   [SETS][WAYS];      // 0 is most recently used
    logic [WAYS-1:0]   valid_arr [SETS];

    logic [SET_W-1:0]  set_idx;
    tag_t              tag;
    be_size_e          size;
    logic              bad_be;
    logic              hit;
    logic [WAY_W-1:0]  hit_way;
    logic [WAY_W-1:0]  victim_way;
    logic [WAY_W-1:0]  way;                         // Way touched by this access
    logic [2:0]        max_age;
    cache_word_u       wd;
    cache_word_u       old_word;
    cache_word_u       new_word;
    cache_word_u       rd_word;

    assign set_idx = addr_i[`CACHE_SET_LSB +: SET_W];
    assign tag     = {addr_i[`CACHE_ADDR_W-1:`CACHE_TAG_LSB], addr_i[`CACHE_BANK_LSB-1:0]};
    assign size    = decode_be(be_i);
    assign bad_be  = (size == BAD);

    // Tag compare over all ways, first match wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (!hit && valid_arr[set_idx][w] && tag_arr[set_idx][w] == tag) begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
        end
    end

    // Victim is the oldest way, strict compare keeps the lowest index on ties
    always_comb begin
        victim_way = '0;
        max_age    = age_arr[set_idx][0];
        for (int w = 1; w < WAYS; w++) begin
            if (age_arr[set_idx][w] > max_age) begin
                max_age    = age_arr[set_idx][w];
                victim_way = WAY_W'(w);
            end
        end
    end

    assign way         = hit ? hit_way : victim_way;
    assign old_word    = data_arr[set_idx][way];    // Hit data, or the line being replaced
    assign wd.word     = wdata_i;

    // Line contents after the access
    always_comb begin
        new_word = old_word;
        if (!wr_i) begin
            if (!hit) begin
                new_word.word = fill_i;             // Read miss takes the fill word
            end
        end else begin
            // Writes merge lanes, on a miss into the evicted word
            case (size)
                BYTE:    new_word.lane[0]   = wd.lane[0];
                HALF:    new_word.lane[1:0] = wd.lane[1:0];
                WORD:    new_word.word      = wd.word;
                default: new_word           = old_word;
            endcase
        end
    end

    // Returned data is the updated line masked to the access size
    always_comb begin
        rd_word.word = '0;
        case (size)
            BYTE:    rd_word.lane[0]   = new_word.lane[0];
            HALF:    rd_word.lane[1:0] = new_word.lane[1:0];
            WORD:    rd_word           = new_word;
            default: ;                              // Bad size returns zero
        endcase
    end

    // Tag, data and age arrays, no reset
    always_ff @(posedge clk) begin
        if (valid_i && !bad_be) begin
            tag_arr[set_idx][way]  <= tag;
            data_arr[set_idx][way] <= new_word;
            for (int w = 0; w < WAYS; w++) begin
                if (WAY_W'(w) == way) begin
                    age_arr[set_idx][w] <= '0;      // Touched way becomes youngest
                end else if (age_arr[set_idx][w] < AGE_MAX) begin
                    age_arr[set_idx][w] <= age_arr[set_idx][w] + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < SETS; s++) begin
                valid_arr[s] <= '0;
            end
        end else if (valid_i && !bad_be) begin
            valid_arr[set_idx][way] <= 1'b1;
        end
    end

    // Response one cycle after dispatch
    always_ff @(posedge clk) begin
        if (reset_i) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            hit_o   <= hit && !bad_be;
            err_o   <= bad_be;
            rdata_o <= rd_word.word;
        end
    end

endmodule

// File: hdl/cache_req_router.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_req_router
    import cache_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        req_valid_i,
    input  logic [`CACHE_ADDR_W-1:0]    req_addr_i,
    input  logic                        req_wr_i,
    input  logic [`CACHE_DATA_W-1:0]    req_wdata_i,
    input  logic [3:0]                  req_be_i,
    input  logic [`CACHE_DATA_W-1:0]    req_fill_i,
    input  logic                        credit_ok_i,    // Merger has room for one more
    output logic                        req_ready_o,
    output logic [`CACHE_NUM_BANKS-1:0] bank_valid_o,   // One-hot dispatch strobe
    output logic [`CACHE_ADDR_W-1:0]    bank_addr_o,
    output logic                        bank_wr_o,
    output logic [`CACHE_DATA_W-1:0]    bank_wdata_o,
    output logic [3:0]                  bank_be_o,
    output logic [`CACHE_DATA_W-1:0]    bank_fill_o
);

    bank_id_t    bank_sel;
    logic        dispatch;
    logic [31:0] issued_cnt;    // Requests sent to the banks since reset

    // Bank bits sit just above the byte offset
    assign bank_sel = req_addr_i[`CACHE_SET_LSB-1:`CACHE_BANK_LSB];

    // Banks never stall, only the merger credit limits acceptance
    assign req_ready_o = credit_ok_i;
    assign dispatch    = req_valid_i && credit_ok_i;

    always_comb begin
        bank_valid_o           = '0;
        bank_valid_o[bank_sel] = dispatch;  // Only the addressed bank sees valid
    end

    // Payload is shared, each bank qualifies it with its own valid
    assign bank_addr_o  = req_addr_i;
    assign bank_wr_o    = req_wr_i;
    assign bank_wdata_o = req_wdata_i;
    assign bank_be_o    = req_be_i;
    assign bank_fill_o  = req_fill_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            issued_cnt <= '0;
        end else if (dispatch) begin
            issued_cnt <= issued_cnt + 32'd1;
        end
    end

endmodule

// File: hdl/cache_pkg.sv
`include "cache_consts.svh"

package cache_pkg;

    typedef logic [`CACHE_BANK_W-1:0] bank_id_t;    // Bank select from the address
    typedef logic [`CACHE_TAG_W-1:0]  tag_t;        // High address bits plus the two low bits

    // Access size, only three byte-enable codes are legal
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD,
        BAD
    } be_size_e;

    // One data word, seen whole or as byte lanes
    typedef union packed {
        logic [`CACHE_DATA_W-1:0]        word;
        logic [`CACHE_DATA_W/8-1:0][7:0] lane;      // lane[0] is the low byte
    } cache_word_u;

    function automatic be_size_e decode_be(input logic [3:0] be);
        case (be)
            4'b0001: return BYTE;
            4'b0011: return HALF;
            4'b1111: return WORD;
            default: return BAD;                    // Any other pattern is rejected
        endcase
    endfunction

endpackage

// File: include/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Datapath widths
`define CACHE_ADDR_W         32
`define CACHE_DATA_W         32

// Cache organisation
`define CACHE_NUM_BANKS      4
`define CACHE_NUM_WAYS       4
`define CACHE_SETS_PER_BANK  64

// Merger entries, also the credit limit of the router
`define CACHE_FIFO_DEPTH     4

// Address split
// bank in addr[3:2], set in addr[9:4], tag from addr[31:10] and addr[1:0]
`define CACHE_BANK_W         2
`define CACHE_BANK_LSB       2
`define CACHE_SET_LSB        4
`define CACHE_TAG_LSB        10
`define CACHE_TAG_W          24

`endif
